// ==== logic/gpio_cfg_pkg.sv ====
`default_nettype none

package gpio_cfg_pkg;

    localparam int PAD_CTRL_BITS = 13;      // Config bits per pad, fixed layout

    // One pad configuration word, MSB field first
    typedef struct packed {
        logic [2:0] dm;                     // Drive mode
        logic       vtrip_sel;              // Input trip point select
        logic       slow_sel;               // Slew rate select
        logic       ana_pol;                // Analog polarity
        logic       ana_sel;                // Analog select
        logic       ana_en;                 // Analog enable
        logic       ib_mode_sel;            // Input buffer mode
        logic       inenb;                  // Input disable
        logic       holdover;               // Hold mode
        logic       outenb;                 // Output disable
        logic       mgmt_ena;               // Bit 0, management owns pad
    } pad_cfg_t;

    // Signals actually driven onto the pad
    typedef struct packed {
        logic out;                          // Pad output level
        logic outenb;                       // Pad output disable
    } pad_drive_t;

    // Pad comes up as a management input
    localparam pad_cfg_t PAD_CFG_RESET = '{
        dm:          3'b001,                // Input only
        vtrip_sel:   1'b0,                  // CMOS trip
        slow_sel:    1'b0,                  // Fast slew
        ana_pol:     1'b0,
        ana_sel:     1'b0,
        ana_en:      1'b0,                  // Digital path
        ib_mode_sel: 1'b0,                  // CMOS input buffer
        inenb:       1'b0,                  // Input enabled
        holdover:    1'b0,
        outenb:      1'b1,                  // Output off
        mgmt_ena:    1'b0
    };

    // Chain sequencer states
    typedef enum logic [1:0] {
        CHAIN_IDLE  = 2'd0,                 // Waiting for a request
        CHAIN_SHIFT = 2'd1,                 // Bits moving down the chain
        CHAIN_LOAD  = 2'd2                  // Load strobe to all pads
    } chain_state_e;

endpackage

`default_nettype wire

// ==== logic/gpio_chain_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

// Holds one config word per pad and serializes them into the chain
module gpio_chain_ctrl #(
    parameter  int NUM_PADS = 4,                            // Pads on the chain
    localparam int ADDR_W   = (NUM_PADS > 1) ? $clog2(NUM_PADS) : 1
) (
    input  logic                   load_data,               // Clock
    input  logic                   int_reset,               // Async reset, active high
    input  logic                   cfg_we,                  // Register write strobe
    input  logic [ADDR_W-1:0]      cfg_addr,                // Pad index
    input  gpio_cfg_pkg::pad_cfg_t cfg_data,                // Word to store
    input  logic                   xfer_start,              // Transfer request strobe
    output logic                   busy,                    // Transfer in progress
    output logic                   shift_en,                // Shift strobe to chain
    output logic                   load,                    // Load strobe to chain
    output logic                   ser_out                  // Head of the chain
);
    import gpio_cfg_pkg::*;

    localparam int TOTAL_BITS = NUM_PADS * PAD_CTRL_BITS;   // Bits per transfer
    localparam int CNT_W      = $clog2(TOTAL_BITS);

    pad_cfg_t              cfg_regs [NUM_PADS];             // Register file
    logic [TOTAL_BITS-1:0] snap;                            // Snapshot being shifted
    logic [CNT_W-1:0]      bit_cnt;                         // Bits already shifted
    logic                  armed;                           // Snapshot taken, shift next
    chain_state_e          state;
    logic                  start_ok;                        // Request accepted

    // Requests while armed or busy are dropped
    assign start_ok = xfer_start && (state == CHAIN_IDLE) && !armed;

    // Register file, writable at any time
    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            for (int i = 0; i < NUM_PADS; i++) begin
                cfg_regs[i] <= PAD_CFG_RESET;
            end
        end else if (cfg_we && (int'(cfg_addr) < NUM_PADS)) begin
            cfg_regs[cfg_addr] <= cfg_data;                 // Out of range ignored
        end
    end

    // Snapshot, last pad in the top word so it leaves first
    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            snap <= '0;
        end else if (start_ok) begin
            for (int i = 0; i < NUM_PADS; i++) begin
                snap[i*PAD_CTRL_BITS +: PAD_CTRL_BITS] <= cfg_regs[i];
            end
        end else if (state == CHAIN_SHIFT) begin
            snap <= {snap[TOTAL_BITS-2:0], 1'b0};           // MSB first
        end
    end

    assign ser_out = snap[TOTAL_BITS-1];

    // Sequencer: arm cycle, TOTAL_BITS shifts, one load
    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            state   <= CHAIN_IDLE;
            armed   <= 1'b0;
            bit_cnt <= '0;
        end else begin
            armed <= start_ok;                              // One cycle after capture
            case (state)
                CHAIN_IDLE: begin
                    if (armed) begin
                        state   <= CHAIN_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                CHAIN_SHIFT: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(TOTAL_BITS - 1)) begin
                        state <= CHAIN_LOAD;                // Last bit in place
                    end
                end
                CHAIN_LOAD: begin
                    state <= CHAIN_IDLE;                    // Pads latch at this edge
                end
                default: begin
                    state <= CHAIN_IDLE;
                end
            endcase
        end
    end

    // Strobes decoded from registered state
    assign busy     = (state != CHAIN_IDLE);
    assign shift_en = (state == CHAIN_SHIFT);
    assign load     = (state == CHAIN_LOAD);

endmodule

`default_nettype wire

// ==== logic/gpio_control_block.sv ====
`timescale 1ns/1ns
`default_nettype none

// One per pad. Shift stage, latched config word and signal routing
module gpio_control_block (
    input  logic                     load_data,   // Clock
    input  logic                     int_reset,   // Async reset, active high
    input  logic                     shift_en,    // Shift strobe from controller
    input  logic                     load,        // Load strobe from controller
    input  logic                     ser_in,      // From previous stage
    input  logic                     user_out,    // User side to pad
    input  logic                     user_oeb,    // User output disable
    input  logic                     mgmt_out,    // Management side to pad
    input  logic                     pad_in,      // From pad
    output logic                     ser_out,     // To next stage
    output gpio_cfg_pkg::pad_cfg_t   cfg_out,     // Static pad settings
    output gpio_cfg_pkg::pad_drive_t pad_drive,   // Out and outenb to pad
    output logic                     user_in,     // Pad to user side
    output logic                     mgmt_in      // Pad to management side
);
    import gpio_cfg_pkg::*;

    logic [PAD_CTRL_BITS-1:0] shift_reg;          // Serial stage
    pad_cfg_t                 cfg_q;              // Latched config word
    logic                     pull_mode;          // Output drives pull select

    assign ser_out = shift_reg[PAD_CTRL_BITS-1];  // MSB leaves first

    // Shift stage, MSB first
    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            shift_reg <= '0;
        end else if (shift_en) begin
            shift_reg <= {shift_reg[PAD_CTRL_BITS-2:0], ser_in};
        end
    end

    // Latched config, updated only on load
    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            cfg_q <= PAD_CFG_RESET;                 // Management input mode
        end else if (load) begin
            cfg_q <= pad_cfg_t'(shift_reg);
        end
    end

    assign cfg_out = cfg_q;                       // Straight to pad cells

    // dm 01x with input enabled selects pull up or down
    assign pull_mode = (cfg_q.dm[2:1] == 2'b01) && !cfg_q.inenb;

    // Pad output level
    always_comb begin
        if (cfg_q.mgmt_ena) begin
            pad_drive.out = mgmt_out;             // Management owns pad
        end else if (pull_mode) begin
            pad_drive.out = ~cfg_q.dm[0];         // Opposite of dm[0] sets pull
        end else begin
            pad_drive.out = user_out;
        end
    end

    // Pad output disable
    always_comb begin
        if (cfg_q.mgmt_ena) begin
            pad_drive.outenb = cfg_q.outenb;      // Fixed by config
        end else if (cfg_q.outenb) begin
            pad_drive.outenb = 1'b1;              // Configured as input
        end else begin
            pad_drive.outenb = user_oeb;          // User controls enable
        end
    end

    // User sees zero while management has the pad
    assign user_in = cfg_q.mgmt_ena ? 1'b0 : pad_in;

    // Management input path, only with input buffer on
    assign mgmt_in = cfg_q.inenb ? 1'b0 : pad_in;

endmodule

`default_nettype wire

// ==== logic/gpio_frame.sv ====
`timescale 1ns/1ns
`default_nettype none

// Controller plus daisy chain of per-pad control blocks
module gpio_frame #(
    parameter  int NUM_PADS = 4,                                // Pads in the frame
    localparam int ADDR_W   = (NUM_PADS > 1) ? $clog2(NUM_PADS) : 1
) (
    input  logic                                    load_data,  // Clock
    input  logic                                    int_reset,  // Async reset, active high
    input  logic                                    cfg_we,     // Config write strobe
    input  logic [ADDR_W-1:0]                       cfg_addr,   // Pad index
    input  gpio_cfg_pkg::pad_cfg_t                  cfg_data,   // Word to write
    input  logic                                    xfer_start, // Start chain transfer
    input  logic [NUM_PADS-1:0]                     user_out,   // User side outputs
    input  logic [NUM_PADS-1:0]                     user_oeb,   // User output disables
    input  logic [NUM_PADS-1:0]                     mgmt_out,   // Management outputs
    input  logic [NUM_PADS-1:0]                     pad_in,     // Pad input levels
    output logic                                    busy,       // Transfer running
    output gpio_cfg_pkg::pad_cfg_t   [NUM_PADS-1:0] pad_cfg,    // Static settings per pad
    output gpio_cfg_pkg::pad_drive_t [NUM_PADS-1:0] pad_drive,  // Pad out and outenb
    output logic [NUM_PADS-1:0]                     user_in,    // Pad to user
    output logic [NUM_PADS-1:0]                     mgmt_in     // Pad to management
);

    logic [NUM_PADS:0] chain;       // Serial links, top bit is the chain tail
    logic              shift_en;    // Broadcast shift strobe
    logic              load;        // Broadcast load strobe

    gpio_chain_ctrl #(
        .NUM_PADS   (NUM_PADS)
    ) chain_ctrl_i (
        .load_data  (load_data),
        .int_reset  (int_reset),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .xfer_start (xfer_start),
        .busy       (busy),
        .shift_en   (shift_en),
        .load       (load),
        .ser_out    (chain[0])      // Feeds pad 0
    );

    // Pad i takes chain[i] and passes on chain[i+1]
    for (genvar i = 0; i < NUM_PADS; i++) begin : g_pad
        gpio_control_block ctrl_blk_i (
            .load_data (load_data),
            .int_reset (int_reset),
            .shift_en  (shift_en),
            .load      (load),
            .ser_in    (chain[i]),
            .user_out  (user_out[i]),
            .user_oeb  (user_oeb[i]),
            .mgmt_out  (mgmt_out[i]),
            .pad_in    (pad_in[i]),
            .ser_out   (chain[i+1]),
            .cfg_out   (pad_cfg[i]),
            .pad_drive (pad_drive[i]),
            .user_in   (user_in[i]),
            .mgmt_in   (mgmt_in[i])
        );
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pad configuration testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    -f src.f \
    --top-module gpio_frame_tb \
    --Mdir obj_dir \
    -o gpio_frame_tb_sim

./obj_dir/gpio_frame_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== sim/gpio_frame_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module gpio_frame_tb;
    import gpio_cfg_pkg::*;

    localparam int NUM_PADS    = 4;
    localparam int ADDR_W      = $clog2(NUM_PADS);
    localparam int XFER_EDGES  = NUM_PADS * PAD_CTRL_BITS + 2;  // Start edge to latch edge
    localparam int CLK_NS      = 8;
    localparam int WATCHDOG_NS = 20 * XFER_EDGES * CLK_NS + 4000;  // 20 transfers plus slack

    logic                     load_data;
    logic                     int_reset;
    logic                     cfg_we;
    logic [ADDR_W-1:0]        cfg_addr;
    pad_cfg_t                 cfg_data;
    logic                     xfer_start;
    logic [NUM_PADS-1:0]      user_out;
    logic [NUM_PADS-1:0]      user_oeb;
    logic [NUM_PADS-1:0]      mgmt_out;
    logic [NUM_PADS-1:0]      pad_in;
    logic                     busy;
    pad_cfg_t [NUM_PADS-1:0]   pad_cfg;
    pad_drive_t [NUM_PADS-1:0] pad_drive;
    logic [NUM_PADS-1:0]      user_in;
    logic [NUM_PADS-1:0]      mgmt_in;

    pad_cfg_t regs_m [NUM_PADS];       // Model of controller register file
    pad_cfg_t latched_m [NUM_PADS];    // Model of latched words in the pads
    int       errors;
    int       tests_run;
    int       tests_failed;
    int       errs_at_start;           // Error count when the test began
    string    test_name;

    gpio_frame #(
        .NUM_PADS   (NUM_PADS)
    ) gpio_frame_i (
        .load_data  (load_data),
        .int_reset  (int_reset),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .xfer_start (xfer_start),
        .user_out   (user_out),
        .user_oeb   (user_oeb),
        .mgmt_out   (mgmt_out),
        .pad_in     (pad_in),
        .busy       (busy),
        .pad_cfg    (pad_cfg),
        .pad_drive  (pad_drive),
        .user_in    (user_in),
        .mgmt_in    (mgmt_in)
    );

    always #(CLK_NS / 2) load_data = ~load_data;  // 8 ns period

    task automatic check_cfg(input string name, input pad_cfg_t exp, input pad_cfg_t act);
        if (act !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_drive(input string name, input pad_drive_t exp, input pad_drive_t act);
        if (act !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // Expected pad drive from the routing rules
    function automatic pad_drive_t expect_drive(input pad_cfg_t c, input logic uo,
                                                input logic uoeb, input logic mo);
        pad_drive_t d;
        if (c.mgmt_ena) begin
            d.out = mo;
        end else if (c.dm[2:1] == 2'b01 && !c.inenb) begin
            d.out = ~c.dm[0];                   // Pull direction
        end else begin
            d.out = uo;
        end
        if (c.mgmt_ena) begin
            d.outenb = c.outenb;
        end else if (c.outenb) begin
            d.outenb = 1'b1;
        end else begin
            d.outenb = uoeb;
        end
        return d;
    endfunction

    function automatic pad_cfg_t rand_cfg();
        logic [31:0] r;
        r = $urandom;
        return r[PAD_CTRL_BITS-1:0];
    endfunction

    task automatic next_cycle();
        @(posedge load_data);
        #1;                                     // Drive just after the edge
    endtask

    task automatic drive_random_pins();
        logic [31:0] r;
        r = $urandom;
        user_out = r[NUM_PADS-1:0];
        r = $urandom;
        user_oeb = r[NUM_PADS-1:0];
        r = $urandom;
        mgmt_out = r[NUM_PADS-1:0];
        r = $urandom;
        pad_in = r[NUM_PADS-1:0];
    endtask

    task automatic check_routing();
        string n;
        for (int p = 0; p < NUM_PADS; p++) begin
            n = $sformatf("pad_drive[%0d]", p);
            check_drive(n, expect_drive(latched_m[p], user_out[p], user_oeb[p], mgmt_out[p]),
                        pad_drive[p]);
            n = $sformatf("user_in[%0d]", p);
            check_bit(n, latched_m[p].mgmt_ena ? 1'b0 : pad_in[p], user_in[p]);
            n = $sformatf("mgmt_in[%0d]", p);
            check_bit(n, latched_m[p].inenb ? 1'b0 : pad_in[p], mgmt_in[p]);
        end
    endtask

    task automatic check_all_cfg();
        for (int p = 0; p < NUM_PADS; p++) begin
            check_cfg($sformatf("pad_cfg[%0d]", p), latched_m[p], pad_cfg[p]);
        end
    endtask

    task automatic route_cycles(input int n);
        repeat (n) begin
            next_cycle();
            drive_random_pins();
            @(negedge load_data);               // Outputs settled
            check_routing();
        end
    endtask

    task automatic write_cfg(input int addr, input pad_cfg_t data);
        next_cycle();
        cfg_we   = 1'b1;
        cfg_addr = ADDR_W'(addr);
        cfg_data = data;
        next_cycle();                           // Write taken at that edge
        cfg_we   = 1'b0;
        regs_m[addr] = data;
    endtask

    // One chain transfer, checked edge by edge; traffic adds a dropped start and writes
    task automatic do_transfer(input bit traffic);
        pad_cfg_t snap_m [NUM_PADS];
        int       edges;
        for (int p = 0; p < NUM_PADS; p++) begin
            snap_m[p] = regs_m[p];
        end
        next_cycle();
        xfer_start = 1'b1;
        next_cycle();                           // Edge 0 samples the request
        xfer_start = 1'b0;
        edges = 0;
        while (edges < XFER_EDGES) begin
            @(posedge load_data);
            #1;
            edges++;
            cfg_we     = 1'b0;
            xfer_start = 1'b0;
            if (traffic && edges == 4) begin
                xfer_start = 1'b1;              // Must be dropped while busy
            end
            if (traffic && edges >= 6 && edges < 6 + NUM_PADS) begin
                cfg_we   = 1'b1;
                cfg_addr = ADDR_W'(edges - 6);
                cfg_data = rand_cfg();
                regs_m[edges - 6] = cfg_data;
            end
            @(negedge load_data);
            if (edges == XFER_EDGES) begin
                for (int p = 0; p < NUM_PADS; p++) begin
                    latched_m[p] = snap_m[p];
                end
                check_bit("busy", 1'b0, busy);  // Falls with the latch edge
            end else begin
                check_bit("busy", 1'b1, busy);
            end
            check_all_cfg();                    // Old words until the last edge
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errs_at_start = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors == errs_at_start) begin
            $display("test %0d %s: pass", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", tests_run, test_name,
                     errors - errs_at_start);
        end
    endtask

    initial begin
        pad_cfg_t c;
        void'($urandom(32'h6668));              // Fixed seed for the whole run
        load_data  = 1'b0;
        int_reset  = 1'b1;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_data   = '0;
        xfer_start = 1'b0;
        user_out   = '0;
        user_oeb   = '0;
        mgmt_out   = '0;
        pad_in     = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int p = 0; p < NUM_PADS; p++) begin
            regs_m[p]    = PAD_CFG_RESET;
            latched_m[p] = PAD_CFG_RESET;
        end
        repeat (3) @(posedge load_data);
        #1;
        int_reset = 1'b0;

        start_test("reset state");
        @(negedge load_data);
        check_bit("busy", 1'b0, busy);
        check_all_cfg();
        route_cycles(8);
        finish_test();

        start_test("load random words");
        for (int p = 0; p < NUM_PADS; p++) begin
            write_cfg(p, rand_cfg());
        end
        do_transfer(1'b0);
        finish_test();

        start_test("management owned pads");
        for (int p = 0; p < NUM_PADS; p++) begin
            c = rand_cfg();
            c.mgmt_ena = 1'b1;
            write_cfg(p, c);
        end
        do_transfer(1'b0);
        route_cycles(16);
        finish_test();

        start_test("user owned pads");
        repeat (3) begin
            for (int p = 0; p < NUM_PADS; p++) begin
                c = rand_cfg();
                c.mgmt_ena = 1'b0;
                if (p == 0) begin
                    c.dm[2:1] = 2'b01;          // Pad 0 always in pull mode
                    c.inenb   = 1'b0;
                end
                write_cfg(p, c);
            end
            do_transfer(1'b0);
            route_cycles(12);
        end
        finish_test();

        start_test("writes and start during transfer");
        for (int p = 0; p < NUM_PADS; p++) begin
            write_cfg(p, rand_cfg());
        end
        do_transfer(1'b1);                      // Old words land, new ones queued
        repeat (3) begin
            next_cycle();
            @(negedge load_data);
            check_bit("busy", 1'b0, busy);      // Dropped start left no transfer
        end
        do_transfer(1'b0);
        route_cycles(6);
        finish_test();

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns, chain state %s",
                 WATCHDOG_NS, gpio_frame_i.chain_ctrl_i.state.name());
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
logic/gpio_cfg_pkg.sv
logic/gpio_control_block.sv
logic/gpio_chain_ctrl.sv
logic/gpio_frame.sv
sim/gpio_frame_tb.sv
